// File: design/lsp_az_pkg.sv
`default_nettype none

package lsp_az_pkg;

	//////////////////////////////////////////////////
	// Widths and scratch RAM size
	//////////////////////////////////////////////////
	localparam int ADDR_W    = 11;
	localparam int DATA_W    = 32;
	localparam int OP_W      = 16;
	localparam int MEM_DEPTH = 2048;

	typedef logic [ADDR_W-1:0] mem_addr_t;
	typedef logic signed [DATA_W-1:0] mem_word_t;
	typedef logic signed [OP_W-1:0] op_word_t;

	// A Q24 value seen whole or as the hi/lo pair used by the 32x16 multiply
	typedef union packed {
		mem_word_t w;
		struct packed {
			op_word_t        hi;
			logic [OP_W-1:0] lo;
		} h;
	} dpf_word_t;

	typedef enum logic [2:0] {
		L_MULT,
		L_MAC,
		L_MSU,
		L_ADD,
		L_SUB,
		L_SHR_R,
		L_SHL1,
		MPY_32_16
	} basic_op_t;

	//////////////////////////////////////////////////
	// Scratch memory map
	//////////////////////////////////////////////////
	localparam mem_addr_t LSP_BASE = 11'h010;
	localparam mem_addr_t F1_BASE  = 11'h020;
	localparam mem_addr_t F2_BASE  = 11'h028;
	localparam mem_addr_t AZ_BASE  = 11'h030;

	localparam int LSP_ORDER  = 10;
	localparam int HALF_ORDER = 5;

	// Q-format constants
	localparam mem_word_t F_ONE_Q24 = 32'sd16777216;
	localparam mem_word_t A0_Q12    = 32'sd4096;
	localparam op_word_t  AZ_SHIFT  = 16'sd13;
	// Q15 to Q24 step, the factor two of L_mult completes the 2*lsp term
	localparam op_word_t  LSP_SCALE = 16'sd512;

endpackage

`default_nettype wire

// File: design/basic_op_if.sv
`default_nettype none

// One operator request per cycle, result comes back in the same cycle
interface basic_op_if
	import lsp_az_pkg::*;
();

	basic_op_t op;
	// Long operand, accumulator or 32-bit multiplicand
	mem_word_t a;
	// Short factor or shift count
	op_word_t  b;
	// Second long operand, low half is the Q15 factor of the multiplies
	mem_word_t c;
	mem_word_t result;
	logic      overflow;

	modport lsp_to_az (output op, a, b, c, input result, overflow);
	modport basic_ops (input op, a, b, c, output result, overflow);

endinterface

`default_nettype wire

// File: design/scratch_mem_if.sv
`default_nettype none

// Sequencer side of the scratch RAM, read data one cycle after rd_addr
interface scratch_mem_if
	import lsp_az_pkg::*;
();

	mem_addr_t rd_addr;
	mem_word_t rd_data;
	mem_addr_t wr_addr;
	mem_word_t wr_data;
	// Write lands on the clock edge
	logic      wr_en;

	modport lsp_to_az (
		output rd_addr, wr_addr, wr_data, wr_en,
		input  rd_data
	);

	modport memory (
		input  rd_addr, wr_addr, wr_data, wr_en,
		output rd_data
	);

endinterface

`default_nettype wire

// File: design/basic_ops.sv
`default_nettype none

module basic_ops
	import lsp_az_pkg::*;
(
	basic_op_if.basic_ops ops
);

	dpf_word_t   a_dpf;
	op_word_t    c_short;
	op_word_t    lo_q15;
	logic signed [31:0] lo_prod;
	mem_word_t   lo_term;
	mem_word_t   shifted;
	logic [32:0] prod;
	logic [32:0] sum;
	logic [32:0] out;

	//////////////////////////////////////////////////
	// Saturating helpers, bit 32 of the return is the overflow flag
	//////////////////////////////////////////////////
	function automatic mem_word_t sat_long(input logic neg);
		return neg ? 32'sh8000_0000 : 32'sh7fff_ffff;
	endfunction

	function automatic logic [32:0] l_add(input mem_word_t x, input mem_word_t y);
		logic signed [32:0] s;
		s = {x[31], x} + {y[31], y};
		if (s[32] != s[31])
			return {1'b1, sat_long(s[32])};
		return {1'b0, s[31:0]};
	endfunction

	function automatic logic [32:0] l_sub(input mem_word_t x, input mem_word_t y);
		logic signed [32:0] s;
		s = {x[31], x} - {y[31], y};
		if (s[32] != s[31])
			return {1'b1, sat_long(s[32])};
		return {1'b0, s[31:0]};
	endfunction

	// Only -1 * -1 overflows
	function automatic logic [32:0] l_mult(input op_word_t x, input op_word_t y);
		logic signed [31:0] p;
		p = x * y;
		if (p == 32'sh4000_0000)
			return {1'b1, 32'h7fff_ffff};
		return {1'b0, p[30:0], 1'b0};
	endfunction

	assign a_dpf   = ops.a;
	assign c_short = ops.c[15:0];
	assign shifted = ops.a >>> ops.b[4:0];

	// Low half carries 15 bits, always positive
	assign lo_q15  = {1'b0, a_dpf.h.lo[15:1]};
	assign lo_prod = lo_q15 * ops.b;
	// mult(lo, b) then doubled as in L_mac(.., .., 1)
	assign lo_term = {{15{lo_prod[30]}}, lo_prod[30:15], 1'b0};

	always_comb
	begin
		prod = '0;
		sum  = '0;
		out  = '0;
		case (ops.op)
			L_MULT:
				out = l_mult(c_short, ops.b);
			L_MAC:
			begin
				prod = l_mult(c_short, ops.b);
				sum  = l_add(ops.a, prod[31:0]);
				out  = {prod[32] | sum[32], sum[31:0]};
			end
			L_MSU:
			begin
				prod = l_mult(c_short, ops.b);
				sum  = l_sub(ops.a, prod[31:0]);
				out  = {prod[32] | sum[32], sum[31:0]};
			end
			L_ADD:
				out = l_add(ops.a, ops.c);
			L_SUB:
				out = l_sub(ops.a, ops.c);
			L_SHR_R:
			begin
				// Counts here are never negative
				if (ops.b > 16'sd31)
					out = '0;
				else if (ops.b <= 16'sd0)
					out = {1'b0, ops.a};
				else
					out = {1'b0, shifted + {31'd0, ops.a[ops.b[4:0] - 5'd1]}};
			end
			L_SHL1:
			begin
				if (ops.a[31] != ops.a[30])
					out = {1'b1, sat_long(ops.a[31])};
				else
					out = {1'b0, ops.a[30:0], 1'b0};
			end
			MPY_32_16:
			begin
				prod = l_mult(a_dpf.h.hi, ops.b);
				sum  = l_add(prod[31:0], lo_term);
				out  = {prod[32] | sum[32], sum[31:0]};
			end
			default:
				out = '0;
		endcase
		ops.result   = out[31:0];
		ops.overflow = out[32];
	end

endmodule

`default_nettype wire

// File: design/lsp_to_az.sv
`default_nettype none

module lsp_to_az
	import lsp_az_pkg::*;
(
	input  logic i_clock,
	input  logic i_rst_n,
	input  logic i_start,
	output logic o_done,
	basic_op_if.lsp_to_az    ops,
	scratch_mem_if.lsp_to_az mem
);

	typedef enum logic [4:0] {
		S_IDLE, S_SEED, S_F1, S_LSP_RD, S_COPY_RD, S_COPY,
		S_RD_K, S_RD_K1, S_MPY, S_SHL, S_ADD, S_SUB, S_MSU_RD, S_MSU,
		S_FRD0, S_FRD1, S_FRD2, S_FRD3, S_FSUB,
		S_AZ_SUM, S_AZ_LO, S_AZ_DIF, S_AZ_HI, S_A0
	} state_t;

	state_t     state;
	state_t     state_n;
	logic       poly;
	logic [2:0] i;
	logic [2:0] k;
	logic       done;
	dpf_word_t  rd_word;
	op_word_t   lsp_q;
	mem_word_t  fk;
	mem_word_t  acc;
	mem_word_t  fm;

	function automatic mem_addr_t f_addr(input logic sel, input logic [2:0] idx);
		return (sel ? F2_BASE : F1_BASE) + mem_addr_t'(idx);
	endfunction

	// F values use the whole word, an LSP sits in the low half
	assign rd_word = mem.rd_data;
	assign o_done  = done;

	//////////////////////////////////////////////////
	// Operator requests, memory port and next state
	//////////////////////////////////////////////////
	always_comb
	begin
		state_n     = state;
		ops.op      = L_ADD;
		ops.a       = fk;
		ops.b       = lsp_q;
		ops.c       = acc;
		mem.rd_addr = f_addr(poly, k);
		mem.wr_addr = f_addr(poly, k);
		mem.wr_data = ops.result;
		mem.wr_en   = 1'b0;
		case (state)
			S_IDLE:
				if (i_start)
					state_n = S_SEED;
			S_SEED:
			begin
				mem.rd_addr = LSP_BASE + mem_addr_t'(poly);
				mem.wr_addr = f_addr(poly, 3'd0);
				mem.wr_data = F_ONE_Q24;
				mem.wr_en   = 1'b1;
				state_n     = S_F1;
			end
			// f[1] = -2 * lsp in Q24
			S_F1:
			begin
				ops.op      = L_MULT;
				ops.b       = -LSP_SCALE;
				ops.c       = rd_word.w;
				mem.wr_addr = f_addr(poly, 3'd1);
				mem.wr_en   = 1'b1;
				state_n     = S_LSP_RD;
			end
			S_LSP_RD:
			begin
				mem.rd_addr = LSP_BASE + mem_addr_t'({i - 3'd1, poly});
				state_n     = S_COPY_RD;
			end
			S_COPY_RD:
			begin
				mem.rd_addr = f_addr(poly, i - 3'd2);
				state_n     = S_COPY;
			end
			// Symmetry gives f[i] = f[i-2] before the update
			S_COPY:
			begin
				mem.wr_addr = f_addr(poly, i);
				mem.wr_data = rd_word.w;
				mem.wr_en   = 1'b1;
				state_n     = S_RD_K;
			end
			S_RD_K:
				state_n = S_RD_K1;
			S_RD_K1:
			begin
				mem.rd_addr = f_addr(poly, k - 3'd1);
				state_n     = S_MPY;
			end
			S_MPY:
			begin
				mem.rd_addr = f_addr(poly, k - 3'd2);
				ops.op      = MPY_32_16;
				ops.a       = rd_word.w;
				state_n     = S_SHL;
			end
			S_SHL:
			begin
				ops.op  = L_SHL1;
				ops.a   = acc;
				state_n = S_ADD;
			end
			S_ADD:
			begin
				ops.c   = fm;
				state_n = S_SUB;
			end
			// f[k] = f[k] + f[k-2] - 2 * lsp * f[k-1]
			S_SUB:
			begin
				ops.op    = L_SUB;
				mem.wr_en = 1'b1;
				state_n   = (k == 3'd2) ? S_MSU_RD : S_RD_K;
			end
			S_MSU_RD:
			begin
				mem.rd_addr = f_addr(poly, 3'd1);
				state_n     = S_MSU;
			end
			S_MSU:
			begin
				ops.op      = L_MSU;
				ops.a       = rd_word.w;
				ops.b       = LSP_SCALE;
				ops.c       = {{16{lsp_q[15]}}, lsp_q};
				mem.wr_addr = f_addr(poly, 3'd1);
				mem.wr_en   = 1'b1;
				if (i != 3'(HALF_ORDER))
					state_n = S_LSP_RD;
				else
					state_n = poly ? S_FRD0 : S_SEED;
			end

			//////////////////////////////////////////////////
			// Fold F1 and F2, then form a[k] and a[11-k]
			//////////////////////////////////////////////////
			S_FRD0:
			begin
				mem.rd_addr = f_addr(1'b0, k);
				state_n     = S_FRD1;
			end
			S_FRD1:
			begin
				mem.rd_addr = f_addr(1'b0, k - 3'd1);
				state_n     = S_FRD2;
			end
			S_FRD2:
			begin
				mem.rd_addr = f_addr(1'b1, k);
				ops.c       = rd_word.w;
				state_n     = S_FRD3;
			end
			S_FRD3:
			begin
				mem.rd_addr = f_addr(1'b1, k - 3'd1);
				state_n     = S_FSUB;
			end
			S_FSUB:
			begin
				ops.op  = L_SUB;
				ops.a   = fm;
				ops.c   = rd_word.w;
				state_n = S_AZ_SUM;
			end
			S_AZ_SUM:
				state_n = S_AZ_LO;
			S_AZ_LO, S_AZ_HI:
			begin
				ops.op      = L_SHR_R;
				ops.a       = fm;
				ops.b       = AZ_SHIFT;
				mem.wr_data = {{16{ops.result[15]}}, ops.result[15:0]};
				mem.wr_en   = 1'b1;
				if (state == S_AZ_LO)
				begin
					mem.wr_addr = AZ_BASE + mem_addr_t'(k);
					state_n     = S_AZ_DIF;
				end
				else
				begin
					mem.wr_addr = AZ_BASE + mem_addr_t'(LSP_ORDER + 1) - mem_addr_t'(k);
					state_n     = (k == 3'd1) ? S_A0 : S_FRD0;
				end
			end
			S_AZ_DIF:
			begin
				ops.op  = L_SUB;
				state_n = S_AZ_HI;
			end
			S_A0:
			begin
				mem.wr_addr = AZ_BASE;
				mem.wr_data = A0_Q12;
				mem.wr_en   = 1'b1;
				state_n     = S_IDLE;
			end
			default:
				state_n = S_IDLE;
		endcase
	end

	// Control state and loop counters
	always_ff @(posedge i_clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state <= S_IDLE;
			poly  <= 1'b0;
			i     <= '0;
			k     <= '0;
			done  <= 1'b0;
		end
		else
		begin
			state <= state_n;
			done  <= (state == S_A0);
			case (state)
				S_IDLE:
					poly <= 1'b0;
				S_F1:
					i <= 3'd2;
				S_COPY:
					k <= i;
				S_SUB, S_AZ_HI:
					k <= k - 3'd1;
				S_MSU:
				begin
					i <= i + 3'd1;
					k <= 3'(HALF_ORDER);
					if (i == 3'(HALF_ORDER))
						poly <= ~poly;
				end
				default:
					;
			endcase
		end
	end

	// Operand and partial result registers
	always_ff @(posedge i_clock)
	begin
		case (state)
			S_COPY_RD:
				lsp_q <= rd_word.h.lo;
			S_RD_K1, S_FRD1:
				fk <= rd_word.w;
			S_ADD, S_FRD2:
				fk <= ops.result;
			S_MPY, S_FSUB:
				acc <= ops.result;
			S_SHL:
			begin
				acc <= ops.result;
				fm  <= rd_word.w;
			end
			S_FRD3:
				fm <= rd_word.w;
			S_AZ_SUM, S_AZ_DIF:
				fm <= ops.result;
			default:
				;
		endcase
	end

endmodule

`default_nettype wire

// File: design/scratch_memory_controller.sv
`default_nettype none

module scratch_memory_controller
	import lsp_az_pkg::*;
(
	input  logic      i_clock,
	scratch_mem_if.memory mem,
	input  logic      i_test_sel,
	input  mem_addr_t i_test_write_addr,
	input  logic      i_test_write_en,
	input  mem_word_t i_test_write,
	input  mem_addr_t i_test_read_addr,
	output mem_word_t o_mem_read_data
);

	mem_addr_t wr_addr;
	mem_word_t wr_data;
	logic      wr_en;
	mem_addr_t rd_addr;
	mem_word_t rd_q;
	mem_word_t ram [MEM_DEPTH];

	//////////////////////////////////////////////////
	// Test port or sequencer, all four switch together
	//////////////////////////////////////////////////
	always_comb
	begin
		wr_addr = i_test_sel ? i_test_write_addr : mem.wr_addr;
		wr_data = i_test_sel ? i_test_write : mem.wr_data;
		wr_en   = i_test_sel ? i_test_write_en : mem.wr_en;
		rd_addr = i_test_sel ? i_test_read_addr : mem.rd_addr;
	end

	// Write port A, registered read port B
	always_ff @(posedge i_clock)
	begin
		if (wr_en)
			ram[wr_addr] <= wr_data;
		rd_q <= ram[rd_addr];
	end

	assign mem.rd_data     = rd_q;
	assign o_mem_read_data = rd_q;

endmodule

`default_nettype wire

// File: design/lsp_to_az_pipe.sv
`default_nettype none

module lsp_to_az_pipe
	import lsp_az_pkg::*;
(
	input  logic      i_clock,
	input  logic      i_rst_n,
	input  logic      i_start,
	output logic      o_done,
	input  logic      i_test_sel,
	input  mem_addr_t i_test_write_addr,
	input  logic      i_test_write_en,
	input  mem_word_t i_test_write,
	input  mem_addr_t i_test_read_addr,
	output mem_word_t o_mem_read_data
);

	basic_op_if    op_bus ();
	scratch_mem_if mem_bus ();

	//////////////////////////////////////////////////
	// Sequencer
	//////////////////////////////////////////////////
	lsp_to_az u_lsp_to_az (
		.i_clock (i_clock),
		.i_rst_n (i_rst_n),
		.i_start (i_start),
		.o_done  (o_done),
		.ops     (op_bus.lsp_to_az),
		.mem     (mem_bus.lsp_to_az)
	);

	// Shared saturating operators
	basic_ops u_basic_ops (
		.ops (op_bus.basic_ops)
	);

	// Scratch RAM with test port
	scratch_memory_controller u_scratch_mem (
		.i_clock           (i_clock),
		.mem               (mem_bus.memory),
		.i_test_sel        (i_test_sel),
		.i_test_write_addr (i_test_write_addr),
		.i_test_write_en   (i_test_write_en),
		.i_test_write      (i_test_write),
		.i_test_read_addr  (i_test_read_addr),
		.o_mem_read_data   (o_mem_read_data)
	);

endmodule

`default_nettype wire

// File: test/lsp_to_az_chk.sv
`default_nettype none

module lsp_to_az_chk
	import lsp_az_pkg::*;
(
	input wire logic      i_clock,
	input wire logic      i_rst_n,
	input wire logic      i_start,
	input wire logic      o_done,
	input wire logic [4:0] i_state,
	input wire logic      i_wr_en,
	input wire mem_addr_t i_wr_addr
);

	timeunit 1ns;
	timeprecision 1ps;

	// F1, F2 and the coefficient block are the only targets
	function automatic logic in_work_region(input mem_addr_t addr);
		return (addr >= F1_BASE && addr <= F1_BASE + 11'd5)
			|| (addr >= F2_BASE && addr <= F2_BASE + 11'd5)
			|| (addr >= AZ_BASE && addr <= AZ_BASE + 11'd10);
	endfunction

	done_one_cycle: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_done |=> !o_done)
		else $error("done held for more than one cycle");

	idle_no_write: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(i_state == 5'd0) |-> !i_wr_en)
		else $error("write enable high in idle");

	start_gives_done: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(i_start && i_state == 5'd0) |-> ##[1:1000] o_done)
		else $error("no done after start");

	write_in_region: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_wr_en |-> (i_wr_addr >= LSP_BASE && in_work_region(i_wr_addr)))
		else $error("sequencer write outside work regions");

endmodule

bind lsp_to_az lsp_to_az_chk chk (
	.i_clock   (i_clock),
	.i_rst_n   (i_rst_n),
	.i_start   (i_start),
	.o_done    (o_done),
	.i_state   (state),
	.i_wr_en   (mem.wr_en),
	.i_wr_addr (mem.wr_addr)
);

`default_nettype wire

// File: test/lsp_to_az_tb.sv
`default_nettype none

module lsp_to_az_tb
	import lsp_az_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_VEC   = 3;
	localparam int VEC_WORDS = LSP_ORDER + LSP_ORDER + 1;
	localparam int TIMEOUT   = 2000;

	logic      clk;
	logic      rst_n;
	logic      start;
	logic      done;
	logic      test_sel;
	mem_addr_t test_wr_addr;
	logic      test_wr_en;
	mem_word_t test_wr_data;
	mem_addr_t test_rd_addr;
	mem_word_t rd_data;

	logic [31:0] pat [NUM_VEC*VEC_WORDS];
	logic [31:0] seed;
	int          errors;
	int          checks;
	int          tests_failed;
	int          errors_before;

	lsp_to_az_pipe uut (
		.i_clock           (clk),
		.i_rst_n           (rst_n),
		.i_start           (start),
		.o_done            (done),
		.i_test_sel        (test_sel),
		.i_test_write_addr (test_wr_addr),
		.i_test_write_en   (test_wr_en),
		.i_test_write      (test_wr_data),
		.i_test_read_addr  (test_rd_addr),
		.o_mem_read_data   (rd_data)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////
	task automatic check_word(input string name, input mem_word_t exp, input mem_word_t act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("CHECK FAILED %s expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic report_test(input string name);
		if (errors == errors_before)
			$display("%-32s ok", name);
		else
		begin
			tests_failed++;
			$display("%-32s failed with %0d errors", name, errors - errors_before);
		end
		errors_before = errors;
	endtask

	//////////////////////////////////////////////////
	// Test port access on the falling edge
	//////////////////////////////////////////////////
	task automatic write_word(input mem_addr_t addr, input mem_word_t data);
		@(negedge clk);
		test_sel     = 1'b1;
		test_wr_addr = addr;
		test_wr_data = data;
		test_wr_en   = 1'b1;
		@(negedge clk);
		test_wr_en = 1'b0;
	endtask

	// Read data is registered and stable at the next falling edge
	task automatic read_word(input mem_addr_t addr, output mem_word_t data);
		@(negedge clk);
		test_sel     = 1'b1;
		test_rd_addr = addr;
		@(negedge clk);
		data = rd_data;
	endtask

	task automatic pulse_start();
		@(negedge clk);
		test_sel   = 1'b0;
		test_wr_en = 1'b0;
		start      = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic wait_for_done(output logic seen);
		int n;
		seen = 1'b0;
		n    = 0;
		while (!seen && n < TIMEOUT)
		begin
			@(negedge clk);
			seen = done;
			n++;
		end
		if (!seen)
		begin
			errors++;
			$display("No done pulse within %0d cycles after start", TIMEOUT);
		end
	endtask

	task automatic load_lsps(input int v);
		for (int n = 0; n < LSP_ORDER; n++)
			write_word(LSP_BASE + mem_addr_t'(n), pat[v*VEC_WORDS + n]);
	endtask

	task automatic check_coeffs(input int v, input string name);
		mem_word_t got;
		for (int n = 0; n <= LSP_ORDER; n++)
		begin
			read_word(AZ_BASE + mem_addr_t'(n), got);
			check_word($sformatf("%s a[%0d]", name, n),
				pat[v*VEC_WORDS + LSP_ORDER + n], got);
		end
		read_word(AZ_BASE, got);
		check_word($sformatf("%s a[0] unity", name), A0_Q12, got);
	endtask

	task automatic run_vector(input int v, input string name);
		logic seen;
		load_lsps(v);
		pulse_start();
		wait_for_done(seen);
		if (seen)
			check_coeffs(v, name);
	endtask

	initial
	begin
		mem_word_t got;
		mem_word_t written [16];
		logic      seen;

		rst_n         = 1'b0;
		start         = 1'b0;
		test_sel      = 1'b1;
		test_wr_addr  = '0;
		test_wr_en    = 1'b0;
		test_wr_data  = '0;
		test_rd_addr  = '0;
		errors        = 0;
		checks        = 0;
		tests_failed  = 0;
		errors_before = 0;
		seed          = 32'h5172_be1c;
		$readmemh("test/lsp_patterns.mem", pat);

		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// Idle after reset
		for (int n = 0; n < 20; n++)
		begin
			@(negedge clk);
			check_flag("idle done", 1'b0, done);
		end
		report_test("idle after reset");

		// Round trip above the work regions
		for (int n = 0; n < 16; n++)
		begin
			seed       = xorshift32(seed);
			written[n] = seed;
			write_word(11'h080 + mem_addr_t'(n * 'h45), written[n]);
		end
		for (int n = 0; n < 16; n++)
		begin
			read_word(11'h080 + mem_addr_t'(n * 'h45), got);
			check_word($sformatf("round trip %0d", n), written[n], got);
		end
		report_test("test port round trip");

		for (int v = 0; v < NUM_VEC; v++)
		begin
			run_vector(v, $sformatf("vector %0d", v));
			report_test($sformatf("coefficients vector %0d", v));
			for (int n = 0; n < LSP_ORDER; n++)
			begin
				read_word(LSP_BASE + mem_addr_t'(n), got);
				check_word($sformatf("vector %0d lsp[%0d]", v, n), pat[v*VEC_WORDS + n], got);
			end
			report_test($sformatf("lsp kept vector %0d", v));
		end

		// Each run follows a different vector so stale F values would show
		run_vector(0, "b2b vector 0");
		run_vector(2, "b2b vector 2");
		run_vector(1, "b2b vector 1");
		report_test("back to back runs");

		// Extra start in the middle of a run
		load_lsps(2);
		pulse_start();
		repeat (6) @(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		wait_for_done(seen);
		for (int n = 0; n < 400; n++)
		begin
			@(negedge clk);
			check_flag("restart single done", 1'b0, done);
		end
		check_coeffs(2, "restart vector 2");
		report_test("start during run ignored");

		$display("Tests failed: %0d, checks: %0d, errors: %0d", tests_failed, checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: test/lsp_patterns.mem
// Per line: lsp[0..9] Q15 in the low half, then expected a[0..10] Q12 sign-extended
// All LSPs 0.0, all LSPs 0.5, even LSPs 0.0 with odd LSPs 0.5
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00001000 00000000 00005000 00000000 FFFFA000 00000000 FFFFA000 00000000 00005000 00000000 00001000
00004000 00004000 00004000 00004000 00004000 00004000 00004000 00004000 00004000 00004000 00001000 FFFFB000 FFFFF000 00002000 FFFFD000 FFFFD000 FFFFD000 00002000 FFFFF000 FFFFB000 00001000
00000000 00004000 00000000 00004000 00000000 00004000 00000000 00004000 00000000 00004000 00001000 FFFFD800 FFFFC800 FFFFC000 FFFFA800 00005000 00005000 FFFFF800 FFFF9000 FFFF8800 00003800

// File: sources.f
design/lsp_az_pkg.sv
design/basic_op_if.sv
design/scratch_mem_if.sv
design/basic_ops.sv
design/lsp_to_az.sv
design/scratch_memory_controller.sv
design/lsp_to_az_pipe.sv
test/lsp_to_az_chk.sv
test/lsp_to_az_tb.sv
